// File: tmds_pkg.sv
package tmds_pkg;

    // one channel, one pixel clock
    typedef logic [9:0] tmds_sym_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    // running disparity, two's complement
    typedef logic signed [4:0] disp_t;

    // control symbols, indexed by {c1, c0}
    localparam tmds_sym_t CTRL_TOKEN_00 = 10'b1101010100;
    localparam tmds_sym_t CTRL_TOKEN_01 = 10'b0010101011;
    localparam tmds_sym_t CTRL_TOKEN_10 = 10'b0101010100;
    localparam tmds_sym_t CTRL_TOKEN_11 = 10'b1010101011;

    localparam int ENC_LATENCY = 3;   // encoder input to symbol
    localparam int PIPE_LATENCY = 4;  // timing regs to channel symbols

endpackage

// File: video_if.sv
`timescale 1ns/1ps

// raster position and sync from the timing generator
interface video_if;

    logic       hsync;
    logic       vsync;
    logic       de;
    logic [7:0] x;
    logic [7:0] y;

    modport source (
        output hsync,
        output vsync,
        output de,
        output x,
        output y
    );

    modport sink (
        input hsync,
        input vsync,
        input de,
        input x,
        input y
    );

endinterface

// File: pixel_if.sv
`timescale 1ns/1ps

// aligned pixel plus sync, one per clock
interface pixel_if;

    tmds_pkg::pixel_t pix;
    logic             hsync;
    logic             vsync;
    logic             de;

    modport source (
        output pix,
        output hsync,
        output vsync,
        output de
    );

    modport sink (
        input pix,
        input hsync,
        input vsync,
        input de
    );

endinterface

// File: video_timing.sv
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enable,
    video_if.source  vid
);

    // line order is active, front porch, sync, back porch
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int H_TOTAL      = H_SYNC_END + H_BACK;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;
    localparam int V_TOTAL      = V_SYNC_END + V_BACK;
    localparam int CNT_W        = 12;

    logic [CNT_W-1:0] h_cnt;
    logic [CNT_W-1:0] v_cnt;
    logic             h_act;
    logic             v_act;
    logic             h_syn;
    logic             v_syn;
    logic             line_end;

    always_comb
    begin
        h_act    = (h_cnt < H_ACTIVE);
        v_act    = (v_cnt < V_ACTIVE);
        h_syn    = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
        v_syn    = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
        line_end = (h_cnt == CNT_W'(H_TOTAL - 1));
    end

    // raster counters, parked at the origin while disabled
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (!enable)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (line_end)
        begin
            h_cnt <= '0;
            if (v_cnt == CNT_W'(V_TOTAL - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vid.de    <= 1'b0;
            vid.hsync <= 1'b0;
            vid.vsync <= 1'b0;
            vid.x     <= 8'd0;
            vid.y     <= 8'd0;
        end
        else if (!enable)
        begin
            vid.de    <= 1'b0;
            vid.hsync <= 1'b0;
            vid.vsync <= 1'b0;
            vid.x     <= 8'd0;
            vid.y     <= 8'd0;
        end
        else
        begin
            vid.de    <= h_act && v_act;
            vid.hsync <= h_syn;
            vid.vsync <= v_syn;      // whole lines
            vid.x     <= h_act ? h_cnt[7:0] : 8'd0;
            vid.y     <= v_act ? v_cnt[7:0] : 8'd0;
        end
    end

endmodule

// File: ramp_pattern.sv
`timescale 1ns/1ps

module ramp_pattern (
    input  logic     clk,
    input  logic     rst_n,
    video_if.sink    vid,
    pixel_if.source  pix
);

    tmds_pkg::pixel_t ramp;

    // wraps at 256
    always_comb
    begin
        ramp.red   = vid.x;
        ramp.green = vid.y;
        ramp.blue  = vid.x ^ vid.y;
    end

    // one register stage keeps pixel and syncs aligned
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pix.pix   <= '0;
            pix.hsync <= 1'b0;
            pix.vsync <= 1'b0;
            pix.de    <= 1'b0;
        end
        else
        begin
            pix.pix   <= vid.de ? ramp : '0;   // black in blanking
            pix.hsync <= vid.hsync;
            pix.vsync <= vid.vsync;
            pix.de    <= vid.de;
        end
    end

endmodule

// File: tmds_encoder.sv
`timescale 1ns/1ps

module tmds_encoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                de,
    input  logic                c0,
    input  logic                c1,
    input  logic [7:0]          data_in,
    output tmds_pkg::tmds_sym_t data_out
);

    // stage 1
    logic [3:0]      n1_s1;
    logic [7:0]      data_s1;
    logic            de_s1;
    logic [1:0]      ctl_s1;      // {c1, c0}

    // stage 2
    logic            use_xnor;
    logic [8:0]      q_m;
    logic [8:0]      q_m_s2;
    logic [3:0]      n1_s2;
    logic [3:0]      n0_s2;
    logic            de_s2;
    logic [1:0]      ctl_s2;

    // stage 3
    tmds_pkg::disp_t disp;
    tmds_pkg::disp_t bal;
    tmds_pkg::disp_t q8_x2;
    tmds_pkg::disp_t nq8_x2;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            n1_s1   <= 4'd0;
            data_s1 <= 8'd0;
            de_s1   <= 1'b0;
            ctl_s1  <= 2'b00;
        end
        else
        begin
            n1_s1   <= 4'($countones(data_in));
            data_s1 <= data_in;
            de_s1   <= de;
            ctl_s1  <= {c1, c0};
        end
    end

    // xnor chaining when the byte is heavy in ones
    always_comb
    begin
        use_xnor = (n1_s1 > 4'd4) || ((n1_s1 == 4'd4) && !data_s1[0]);
        q_m[0]   = data_s1[0];
        for (int i = 1; i < 8; i++)
        begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_s1[i]) : (q_m[i-1] ^ data_s1[i]);
        end
        q_m[8] = ~use_xnor;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            q_m_s2 <= 9'd0;
            n1_s2  <= 4'd0;
            n0_s2  <= 4'd0;
            de_s2  <= 1'b0;
            ctl_s2 <= 2'b00;
        end
        else
        begin
            q_m_s2 <= q_m;
            n1_s2  <= 4'($countones(q_m[7:0]));
            n0_s2  <= 4'd8 - 4'($countones(q_m[7:0]));
            de_s2  <= de_s1;
            ctl_s2 <= ctl_s1;
        end
    end

    always_comb
    begin
        bal    = tmds_pkg::disp_t'({1'b0, n1_s2}) - tmds_pkg::disp_t'({1'b0, n0_s2});
        q8_x2  = q_m_s2[8] ? tmds_pkg::disp_t'(2) : tmds_pkg::disp_t'(0);
        nq8_x2 = q_m_s2[8] ? tmds_pkg::disp_t'(0) : tmds_pkg::disp_t'(2);
    end

    // output symbol and running disparity
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            data_out <= '0;
            disp     <= '0;
        end
        else if (!de_s2)
        begin
            case (ctl_s2)
                2'b00:   data_out <= tmds_pkg::CTRL_TOKEN_00;
                2'b01:   data_out <= tmds_pkg::CTRL_TOKEN_01;
                2'b10:   data_out <= tmds_pkg::CTRL_TOKEN_10;
                default: data_out <= tmds_pkg::CTRL_TOKEN_11;
            endcase
            disp <= '0;
        end
        else if ((disp == 0) || (bal == 0))
        begin
            data_out <= {~q_m_s2[8], q_m_s2[8],
                         q_m_s2[8] ? q_m_s2[7:0] : ~q_m_s2[7:0]};
            disp     <= q_m_s2[8] ? (disp + bal) : (disp - bal);
        end
        else if (((disp > 0) && (bal > 0)) || ((disp < 0) && (bal < 0)))
        begin
            data_out <= {1'b1, q_m_s2[8], ~q_m_s2[7:0]};   // invert to pull back
            disp     <= disp + q8_x2 - bal;
        end
        else
        begin
            data_out <= {1'b0, q_m_s2[8], q_m_s2[7:0]};
            disp     <= disp - nq8_x2 + bal;
        end
    end

endmodule

// File: dvi_tx_top.sv
`timescale 1ns/1ps

module dvi_tx_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,
    output tmds_pkg::tmds_sym_t tmds_ch0,
    output tmds_pkg::tmds_sym_t tmds_ch1,
    output tmds_pkg::tmds_sym_t tmds_ch2
);

    video_if vid ();
    pixel_if pix ();

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) video_timing_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .vid    (vid.source)
    );

    ramp_pattern ramp_pattern_i (
        .clk   (clk),
        .rst_n (rst_n),
        .vid   (vid.sink),
        .pix   (pix.source)
    );

    // blue carries the syncs
    tmds_encoder enc_ch0_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .de       (pix.de),
        .c0       (pix.hsync),
        .c1       (pix.vsync),
        .data_in  (pix.pix.blue),
        .data_out (tmds_ch0)
    );

    tmds_encoder enc_ch1_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .de       (pix.de),
        .c0       (1'b0),
        .c1       (1'b0),
        .data_in  (pix.pix.green),
        .data_out (tmds_ch1)
    );

    tmds_encoder enc_ch2_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .de       (pix.de),
        .c0       (1'b0),
        .c1       (1'b0),
        .data_in  (pix.pix.red),
        .data_out (tmds_ch2)
    );

endmodule

// File: tb_tmds_ref.svh
`ifndef TB_TMDS_REF_SVH
`define TB_TMDS_REF_SVH

// DVI 8b/10b data encoding with running disparity
function automatic tmds_pkg::tmds_sym_t ref_encode(input logic [7:0] d, input int disp_in,
                                                   output int disp_out);
    int n1;
    int n1q;
    int n0q;
    logic xnor_sel;
    logic [8:0] qm;
    tmds_pkg::tmds_sym_t sym;
    n1 = $countones(d);
    xnor_sel = (n1 > 4) || ((n1 == 4) && (d[0] == 1'b0));
    qm[0] = d[0];
    for (int i = 1; i < 8; i++)
        qm[i] = qm[i-1] ^ d[i] ^ xnor_sel;
    qm[8] = ~xnor_sel;
    n1q = $countones(qm[7:0]);
    n0q = 8 - n1q;
    if ((disp_in == 0) || (n1q == n0q))
    begin
        sym = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        disp_out = qm[8] ? (disp_in + n1q - n0q) : (disp_in + n0q - n1q);
    end
    else if (((disp_in > 0) && (n1q > n0q)) || ((disp_in < 0) && (n0q > n1q)))
    begin
        sym = {1'b1, qm[8], ~qm[7:0]};
        disp_out = disp_in + (qm[8] ? 2 : 0) + n0q - n1q;
    end
    else
    begin
        sym = {1'b0, qm[8], qm[7:0]};
        disp_out = disp_in - (qm[8] ? 0 : 2) + n1q - n0q;
    end
    return sym;
endfunction

// data symbol back to its byte
function automatic logic [7:0] decode_data(input tmds_pkg::tmds_sym_t s);
    logic [7:0] q;
    logic [7:0] d;
    q = s[9] ? ~s[7:0] : s[7:0];
    d[0] = q[0];
    for (int i = 1; i < 8; i++)
        d[i] = q[i] ^ q[i-1] ^ ~s[8];
    return d;
endfunction

// {c1, c0} of a control token, -1 for anything else
function automatic int ctrl_code(input tmds_pkg::tmds_sym_t s);
    case (s)
        tmds_pkg::CTRL_TOKEN_00: return 0;
        tmds_pkg::CTRL_TOKEN_01: return 1;
        tmds_pkg::CTRL_TOKEN_10: return 2;
        tmds_pkg::CTRL_TOKEN_11: return 3;
        default:                 return -1;
    endcase
endfunction

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois, taps 16 14 13 11
endfunction

`endif

// File: tb_dvi_tx.sv
`timescale 1ns/1ps

module tb_dvi_tx;

    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 3;
    localparam int H_BACK   = 3;
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 1;
    localparam int V_BACK   = 1;
    localparam int FRAME    = (H_ACTIVE + H_FRONT + H_SYNC + H_BACK) *
                              (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int RESET_CYCLES = 3;
    localparam int LIMIT = 3 * 40 * 8 + RESET_CYCLES + 20 + 100;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                enable;
    tmds_pkg::tmds_sym_t tmds_ch0;
    tmds_pkg::tmds_sym_t tmds_ch1;
    tmds_pkg::tmds_sym_t tmds_ch2;

    int         errors = 0;
    int         cycles = 0;
    int         frames = 0;
    int         data_total = 0;
    logic [tmds_pkg::PIPE_LATENCY:0] en_hist = '0;   // enable seen at past rising edges

    `include "tb_tmds_ref.svh"

    dvi_tx_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) dvi_tx_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .tmds_ch0 (tmds_ch0),
        .tmds_ch1 (tmds_ch1),
        .tmds_ch2 (tmds_ch2)
    );

    task automatic mismatch(input string test, input int expected, input int actual);
        errors++;
        $display("Mismatch %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
    endtask

    task automatic failure(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    initial
    begin
        forever #20 clk = ~clk;
    end

    // green and red stay on the neutral token in blanking
    assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl_code(tmds_ch0) >= 0) |->
            ((tmds_ch1 == tmds_pkg::CTRL_TOKEN_00) && (tmds_ch2 == tmds_pkg::CTRL_TOKEN_00)))
        else mismatch("blank_ch12", {tmds_pkg::CTRL_TOKEN_00, tmds_pkg::CTRL_TOKEN_00},
                      {$sampled(tmds_ch1), $sampled(tmds_ch2)});

    // stream tracker on the three channels
    always @(posedge clk)
    begin : tracker
        int                  code0;
        int                  next_disp;
        logic                hs;
        logic                vs;
        tmds_pkg::tmds_sym_t syms [3];
        tmds_pkg::tmds_sym_t exp_sym;
        logic [7:0]          bytes [3];
        static bit           seen_token = 1'b0;
        static bit           prev_data = 1'b0;
        static bit           prev_hs = 1'b0;
        static bit           prev_vs = 1'b0;
        static int           x_cnt = 0;
        static int           y_cnt = 0;
        static int           hs_run = 0;
        static int           vs_lines = 0;
        static int           ref_disp [3] = '{0, 0, 0};
        code0 = ctrl_code(tmds_ch0);
        syms[0] = tmds_ch0;
        syms[1] = tmds_ch1;
        syms[2] = tmds_ch2;
        if (!rst_n)
        begin
            seen_token = 1'b0;
            prev_data = 1'b0;
        end
        else if ((code0 < 0) && !seen_token)
        begin
            assert ((tmds_ch0 == '0) && (tmds_ch1 == '0) && (tmds_ch2 == '0))
                else failure("symbol before the first control token is neither 0 nor a token");
        end
        else if (code0 >= 0)
        begin
            seen_token = 1'b1;
            if (prev_data)
            begin
                assert (x_cnt == H_ACTIVE) else mismatch("line_length", H_ACTIVE, x_cnt);
                y_cnt++;
            end
            prev_data = 1'b0;
            hs = code0[0];
            vs = code0[1];
            if (hs)
            begin
                hs_run++;
                if (!prev_hs && vs)
                    vs_lines++;
            end
            else if (prev_hs)
            begin
                assert (hs_run == H_SYNC) else mismatch("hsync_width", H_SYNC, hs_run);
                hs_run = 0;
            end
            if (vs && !prev_vs)
            begin
                assert (y_cnt == V_ACTIVE) else mismatch("active_lines", V_ACTIVE, y_cnt);
                y_cnt = 0;
                frames++;
            end
            if (!vs && prev_vs)
            begin
                assert (vs_lines == V_SYNC) else mismatch("vsync_lines", V_SYNC, vs_lines);
                vs_lines = 0;
            end
            prev_hs = hs;
            prev_vs = vs;
            ref_disp = '{0, 0, 0};
            // raster parked five edges ago
            if (!en_hist[tmds_pkg::PIPE_LATENCY])
                assert (code0 == 0) else mismatch("idle_token", tmds_pkg::CTRL_TOKEN_00,
                                                  tmds_ch0);
        end
        else
        begin
            if (!prev_data)
                x_cnt = 0;
            prev_data = 1'b1;
            assert (en_hist[tmds_pkg::PIPE_LATENCY])
                else failure("data symbol while the raster is disabled");
            for (int c = 0; c < 3; c++)
            begin
                bytes[c] = decode_data(syms[c]);
                exp_sym = ref_encode(bytes[c], ref_disp[c], next_disp);
                ref_disp[c] = next_disp;
                assert (exp_sym == syms[c])
                    else mismatch($sformatf("encode_ch%0d", c), exp_sym, syms[c]);
            end
            assert (bytes[2] == 8'(x_cnt))
                else mismatch("pixel_red", x_cnt & 255, int'(bytes[2]));
            assert (bytes[1] == 8'(y_cnt))
                else mismatch("pixel_green", y_cnt & 255, int'(bytes[1]));
            assert (bytes[0] == 8'(x_cnt ^ y_cnt))
                else mismatch("pixel_blue", (x_cnt ^ y_cnt) & 255, int'(bytes[0]));
            x_cnt++;
            data_total++;
        end
        en_hist = {en_hist[tmds_pkg::PIPE_LATENCY-1:0], enable};
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > LIMIT)
        begin
            $display("Error: run did not finish within %0d clocks", LIMIT);
            $display("errors: %0d, frames: %0d, data symbols: %0d", errors + 1, frames,
                     data_total);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        logic [15:0] lfsr;
        int          gap;
        rst_n = 1'b0;
        enable = 1'b0;
        lfsr = 16'd16350;
        gap = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        enable = 1'b1;
        repeat (2 * FRAME) @(negedge clk);
        enable = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            lfsr = lfsr_step(lfsr);
            gap = gap * 2 + int'(lfsr[0]);
        end
        repeat (5 + gap) @(negedge clk);   // 5 to 20
        enable = 1'b1;
        repeat (FRAME) @(negedge clk);
        enable = 1'b0;
        repeat (tmds_pkg::PIPE_LATENCY + 4) @(negedge clk);
        assert (frames == 3) else mismatch("frame_count", 3, frames);
        assert (data_total == 3 * H_ACTIVE * V_ACTIVE)
            else mismatch("data_count", 3 * H_ACTIVE * V_ACTIVE, data_total);
        $display("errors: %0d, frames: %0d, data symbols: %0d", errors, frames, data_total);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
tmds_pkg.sv
video_if.sv
pixel_if.sv
video_timing.sv
ramp_pattern.sv
tmds_encoder.sv
dvi_tx_top.sv
tb_dvi_tx.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_dvi_tx -f tb.f -o sim_tb \
    > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
